// ==== decode_issue.f ====
decode_pkg.sv
decoded_instr_if.sv
instr_field_decoder.sv
issue_control.sv
operand_stage.sv
decode_issue.sv
decode_issue_assertions.sv
decode_issue_tb.sv

// ==== decode_issue.sv ====
// decode and issue stage top level for the alu and branch units with plain ports
`timescale 1ns/1ps

module decode_issue
    import decode_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          flush,

    // instruction buffer
    input  logic          instr_valid,
    input  instr_t        instr,
    input  xlen_t         instr_pc,
    output logic          pop,
    output logic          illegal_instruction,

    // register file and scoreboard
    output reg_addr_t     rs1_addr,
    output reg_addr_t     rs2_addr,
    input  xlen_t         rs1_data,
    input  xlen_t         rs2_data,
    input  logic          rs1_conflict,
    input  logic          rs2_conflict,
    output logic          rd_issue,
    output reg_addr_t     rd_addr,

    input  logic          alu_ready,
    input  logic          branch_ready,

    // alu bundle
    output logic          alu_valid,
    output alu_operand_t  alu_in1,
    output alu_operand_t  alu_in2,
    output xlen_t         alu_shifter_in,
    output logic          alu_subtract,
    output logic          alu_arith,
    output logic          alu_lshift,
    output alu_op_t       alu_op,
    output alu_logic_op_t alu_logic_op,

    // branch bundle
    output logic          branch_valid,
    output xlen_t         branch_rs1,
    output xlen_t         branch_rs2,
    output xlen_t         branch_pc,
    output fn3_t          branch_fn3,
    output logic          branch_use_signed,
    output logic          branch_jal,
    output logic          branch_jalr,
    output logic          branch_rdx0
);

    decoded_instr_if dec_if ();

    logic alu_issue;
    logic branch_issue;

    assign rs1_addr            = dec_if.rs1_addr;
    assign rs2_addr            = dec_if.rs2_addr;
    assign illegal_instruction = dec_if.illegal;

    instr_field_decoder u_decoder (
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .dec         (dec_if.decoder)
    );

    issue_control u_issue (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .flush        (flush),
        .dec          (dec_if.consumer),
        .rs1_conflict (rs1_conflict),
        .rs2_conflict (rs2_conflict),
        .alu_ready    (alu_ready),
        .branch_ready (branch_ready),
        .alu_issue    (alu_issue),
        .branch_issue (branch_issue),
        .pop          (pop),
        .rd_issue     (rd_issue),
        .rd_addr      (rd_addr)
    );

    operand_stage u_operands (
        .clk               (clk),
        .rst               (rst),
        .dec               (dec_if.consumer),
        .alu_issue         (alu_issue),
        .branch_issue      (branch_issue),
        .rs1_data          (rs1_data),
        .rs2_data          (rs2_data),
        .alu_valid         (alu_valid),
        .alu_in1           (alu_in1),
        .alu_in2           (alu_in2),
        .alu_shifter_in    (alu_shifter_in),
        .alu_subtract      (alu_subtract),
        .alu_arith         (alu_arith),
        .alu_lshift        (alu_lshift),
        .alu_op            (alu_op),
        .alu_logic_op      (alu_logic_op),
        .branch_valid      (branch_valid),
        .branch_rs1        (branch_rs1),
        .branch_rs2        (branch_rs2),
        .branch_pc         (branch_pc),
        .branch_fn3        (branch_fn3),
        .branch_use_signed (branch_use_signed),
        .branch_jal        (branch_jal),
        .branch_jalr       (branch_jalr),
        .branch_rdx0       (branch_rdx0)
    );

endmodule

// ==== decode_issue_assertions.sv ====
// handshake rules of the decode/issue stage that the testbench binds onto decode_issue
`timescale 1ns/1ps

module decode_issue_assertions (
    input logic clk,
    input logic rst,
    input logic pop,
    input logic illegal_instruction,
    input logic alu_issue,
    input logic branch_issue,
    input logic alu_valid,
    input logic branch_valid
);

    // a pop always goes to exactly one unit
    pop_one_unit: assert property (@(posedge clk) disable iff (rst)
        pop |-> (alu_issue ^ branch_issue))
        else $error("pop without exactly one issue pulse");

    illegal_no_pop: assert property (@(posedge clk) disable iff (rst)
        illegal_instruction |-> !pop)
        else $error("illegal instruction popped");

    // ----------------------------------------
    // strobe timing
    // ----------------------------------------
    alu_valid_delay: assert property (@(posedge clk) disable iff (rst)
        alu_valid == $past(alu_issue))
        else $error("alu_valid does not trail alu_issue");

    branch_valid_delay: assert property (@(posedge clk) disable iff (rst)
        branch_valid == $past(branch_issue))
        else $error("branch_valid does not trail branch_issue");

    valid_low_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> (!alu_valid && !branch_valid))
        else $error("valid strobe high right after reset");

endmodule

bind decode_issue decode_issue_assertions u_assertions (.*);

// ==== decode_issue_tb.sv ====
// self-checking testbench for decode_issue with buffer, register file and scoreboard models
`timescale 1ns/1ps

module decode_issue_tb
    import decode_pkg::*;
;

    typedef struct packed {
        alu_operand_t  in1;
        alu_operand_t  in2;
        xlen_t         shifter;
        logic          sub;
        logic          arith;
        logic          lshift;
        alu_op_t       op;
        alu_logic_op_t lop;
    } alu_bundle_t;

    typedef struct packed {
        xlen_t rs1;
        xlen_t rs2;
        xlen_t pc;
        fn3_t  fn3;
        logic  use_signed;
        logic  jal;
        logic  jalr;
        logic  rdx0;
    } branch_bundle_t;

    typedef struct packed {
        instr_t i;
        xlen_t  pc;
    } entry_t;

    logic clk, rst, flush, instr_valid, alu_ready, branch_ready;
    instr_t instr;
    xlen_t instr_pc, rs1_data, rs2_data;
    logic rs1_conflict, rs2_conflict;
    reg_addr_t rs1_addr, rs2_addr, rd_addr;
    logic pop, illegal_instruction, rd_issue;
    logic alu_valid, alu_subtract, alu_arith, alu_lshift;
    alu_operand_t alu_in1, alu_in2;
    xlen_t alu_shifter_in;
    alu_op_t alu_op;
    alu_logic_op_t alu_logic_op;
    logic branch_valid, branch_use_signed, branch_jal, branch_jalr, branch_rdx0;
    xlen_t branch_rs1, branch_rs2, branch_pc;
    fn3_t branch_fn3;

    xlen_t regs [32];
    logic [31:0] busy;   // scoreboard conflict mask
    entry_t buf_q[$];
    alu_bundle_t alu_exp_q[$];
    branch_bundle_t br_exp_q[$];
    integer seed = 64905;
    int errors = 0;
    int tests = 0;
    int failed = 0;
    int pops = 0;
    int valids = 0;
    xlen_t next_pc = 32'h0000_1000;

    decode_issue dut (.*);

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];
    assign rs1_conflict = busy[rs1_addr];
    assign rs2_conflict = busy[rs2_addr];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // expected bundles from the decode rules
    // ----------------------------------------
    function automatic void ref_operands(input instr_t i, input xlen_t pc, input xlen_t r1,
                                         input xlen_t r2, output alu_bundle_t a,
                                         output branch_bundle_t b);
        logic [4:0] opc;
        fn3_t f3;
        logic upper;
        xlen_t x1, x2;
        opc = i[6:2];
        f3 = i[14:12];
        upper = (opc == LUI_T) || (opc == AUIPC_T);
        x1 = (opc == LUI_T) ? '0 : (opc == AUIPC_T) ? pc : r1;
        if (upper) x2 = {i[31:12], 12'b0};
        else if (opc == ARITH_T) x2 = r2;
        else x2 = {{20{i[31]}}, i[31:20]};
        a.in1 = {x1[31] & ~f3[0], x1};
        a.in2 = {x2[31] & ~f3[0], x2};
        for (int k = 0; k < 32; k++) begin
            a.shifter[k] = f3[2] ? r1[k] : r1[31-k];  // right shifts keep rs1 as is
        end
        a.sub = !upper && (f3 == SLT_FN3 || f3 == SLTU_FN3 ||
                           (f3 == ADD_SUB_FN3 && i[30] && opc == ARITH_T));
        a.arith = r1[31] & i[30];
        a.lshift = ~f3[2];
        if (upper || !(f3 inside {SLT_FN3, SLTU_FN3, SLL_FN3, SRA_FN3})) a.op = ALU_ADD_SUB;
        else if (f3 inside {SLT_FN3, SLTU_FN3}) a.op = ALU_SLT;
        else a.op = ALU_SHIFT;
        if (upper) a.lop = ALU_LOGIC_ADD;
        else if (f3 == XOR_FN3) a.lop = ALU_LOGIC_XOR;
        else if (f3 == OR_FN3) a.lop = ALU_LOGIC_OR;
        else if (f3 == AND_FN3) a.lop = ALU_LOGIC_AND;
        else a.lop = ALU_LOGIC_ADD;
        b = '{r1, r2, pc, f3, !(f3 == BLTU_FN3 || f3 == BGEU_FN3), opc == JAL_T,
              opc == JALR_T, (i[11:7] == 0) || (opc == BRANCH_T)};
    endfunction

    task automatic report_value(string name, logic [63:0] e, logic [63:0] a);
        errors++;
        $display("ERROR at %0t: %s expected %0h actual %0h", $time, name, e, a);
    endtask

    task automatic check_alu(alu_bundle_t e, alu_bundle_t a);
        if (e.in1 !== a.in1) report_value("alu_in1", e.in1, a.in1);
        if (e.in2 !== a.in2) report_value("alu_in2", e.in2, a.in2);
        if (e.shifter !== a.shifter) report_value("alu_shifter_in", e.shifter, a.shifter);
        if (e.sub !== a.sub) report_value("alu_subtract", e.sub, a.sub);
        if (e.arith !== a.arith) report_value("alu_arith", e.arith, a.arith);
        if (e.lshift !== a.lshift) report_value("alu_lshift", e.lshift, a.lshift);
        if (e.op !== a.op) report_value("alu_op", e.op, a.op);
        if (e.lop !== a.lop) report_value("alu_logic_op", e.lop, a.lop);
    endtask

    task automatic check_branch(branch_bundle_t e, branch_bundle_t a);
        if (e.rs1 !== a.rs1) report_value("branch_rs1", e.rs1, a.rs1);
        if (e.rs2 !== a.rs2) report_value("branch_rs2", e.rs2, a.rs2);
        if (e.pc !== a.pc) report_value("branch_pc", e.pc, a.pc);
        if (e.fn3 !== a.fn3) report_value("branch_fn3", e.fn3, a.fn3);
        if (e.use_signed !== a.use_signed) report_value("branch_use_signed", e.use_signed,
                                                        a.use_signed);
        if (e.jal !== a.jal) report_value("branch_jal", e.jal, a.jal);
        if (e.jalr !== a.jalr) report_value("branch_jalr", e.jalr, a.jalr);
        if (e.rdx0 !== a.rdx0) report_value("branch_rdx0", e.rdx0, a.rdx0);
    endtask

    task automatic check_flag(string name, logic e, logic a);
        if (e !== a) report_value(name, e, a);
    endtask

    task automatic check_addr(string name, reg_addr_t e, reg_addr_t a);
        if (e !== a) report_value(name, e, a);
    endtask

    function automatic alu_bundle_t alu_now();
        return '{alu_in1, alu_in2, alu_shifter_in, alu_subtract, alu_arith, alu_lshift,
                 alu_op, alu_logic_op};
    endfunction

    function automatic branch_bundle_t branch_now();
        return '{branch_rs1, branch_rs2, branch_pc, branch_fn3, branch_use_signed,
                 branch_jal, branch_jalr, branch_rdx0};
    endfunction

    // ----------------------------------------
    // buffer model and compare process
    // ----------------------------------------
    always @(posedge clk) begin
        alu_bundle_t ea;
        branch_bundle_t eb;
        logic rd_exp;
        if (!rst) begin
            if (alu_valid) begin
                valids++;
                if (alu_exp_q.size() == 0) begin
                    errors++;
                    $display("alu_valid at %0t with no instruction issued", $time);
                end else check_alu(alu_exp_q.pop_front(), alu_now());
            end
            if (branch_valid) begin
                valids++;
                if (br_exp_q.size() == 0) begin
                    errors++;
                    $display("branch_valid at %0t with no instruction issued", $time);
                end else check_branch(br_exp_q.pop_front(), branch_now());
            end
            if (pop && instr_valid) begin
                pops++;
                ref_operands(instr, instr_pc, regs[instr[19:15]], regs[instr[24:20]], ea, eb);
                if (instr[6:2] inside {BRANCH_T, JAL_T, JALR_T}) br_exp_q.push_back(eb);
                else alu_exp_q.push_back(ea);
                rd_exp = (instr[11:7] != 0) && (instr[6:2] != BRANCH_T);
                check_flag("rd_issue", rd_exp, rd_issue);
                if (rd_exp) check_addr("rd_addr", instr[11:7], rd_addr);
                if (buf_q.size() > 0) void'(buf_q.pop_front());
            end
        end
        instr_valid <= !rst && (buf_q.size() > 0);
        if (buf_q.size() > 0) begin
            instr <= buf_q[0].i;
            instr_pc <= buf_q[0].pc;
        end
    end

    function automatic instr_t enc(logic [4:0] opc, fn3_t f3, reg_addr_t rd, reg_addr_t rs1,
                                   reg_addr_t rs2, logic [6:0] f7);
        return {f7, rs2, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    task automatic push(instr_t i);
        buf_q.push_back('{i, next_pc});
        next_pc += 4;
    endtask

    task automatic randomize_regs();
        for (int r = 1; r < 32; r++) regs[r] = rnd();
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while ((buf_q.size() + alu_exp_q.size() + br_exp_q.size() > 0) && n < 300) begin
            @(posedge clk);
            n++;
        end
        if (buf_q.size() + alu_exp_q.size() + br_exp_q.size() > 0) begin
            errors++;
            $display("timed out at %0t waiting for the buffer and units to drain", $time);
        end
    endtask

    // no pop and no strobe over a few cycles
    task automatic expect_stall(int cycles);
        int p, v;
        p = pops;
        v = valids;
        repeat (cycles) @(posedge clk);
        check_flag("pop_seen", 1'b0, pops != p);
        check_flag("valid_seen", 1'b0, valids != v);
    endtask

    task automatic end_test(string name, int errors_before);
        tests++;
        if (errors != errors_before) failed++;
        $display("test %0s: %0s", name, (errors == errors_before) ? "pass" : "fail");
    endtask

    initial begin
        int e;
        alu_bundle_t held;
        logic [6:0] f7;
        fn3_t f3;
        rst <= 1'b1;
        flush <= 1'b0;
        alu_ready <= 1'b1;
        branch_ready <= 1'b1;
        instr_valid <= 1'b0;
        instr <= '0;
        instr_pc <= '0;
        busy <= '0;
        foreach (regs[r]) regs[r] = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        randomize_regs();

        e = errors;  // random OP and OP-IMM
        for (int k = 0; k < 40; k++) begin
            f3 = fn3_t'(k);
            f7 = (f3 == ADD_SUB_FN3 || f3 == SRA_FN3) ? {1'b0, k[4], 5'b0} : 7'b0;
            if (k % 16 >= 8 && !(f3 inside {SLL_FN3, SRA_FN3})) f7 = rnd();
            push(enc((k % 16 >= 8) ? ARITH_IMM_T : ARITH_T, f3, rnd(), rnd(), rnd(), f7));
        end
        wait_idle();
        end_test("alu random", e);

        e = errors;  // upper immediates including x0
        for (int k = 0; k < 8; k++) begin
            push(enc(k[0] ? AUIPC_T : LUI_T, rnd(), (k < 2) ? 5'd0 : rnd(), rnd(), rnd(), rnd()));
        end
        wait_idle();
        end_test("lui auipc", e);

        e = errors;  // jumps without rd need no branch_ready
        @(posedge clk);
        branch_ready <= 1'b0;
        push(enc(JAL_T, rnd(), 5'd0, rnd(), rnd(), rnd()));
        push(enc(JALR_T, 3'b000, 5'd0, rnd(), rnd(), rnd()));
        for (int k = 0; k < 8; k++) push(enc(BRANCH_T, fn3_t'(k), rnd(), rnd(), rnd(), rnd()));
        wait_idle();
        push(enc(JAL_T, rnd(), 5'd7, rnd(), rnd(), rnd()));
        expect_stall(6);
        branch_ready <= 1'b1;
        push(enc(JALR_T, 3'b000, 5'd9, rnd(), rnd(), rnd()));
        wait_idle();
        end_test("branch unit", e);

        e = errors;  // source conflicts
        busy <= 32'h0000_0002;
        push(enc(ARITH_T, ADD_SUB_FN3, 5'd3, 5'd1, 5'd2, 7'b0));
        expect_stall(6);
        regs[1] = rnd();
        busy <= '0;
        wait_idle();
        busy <= 32'h0000_0010;
        push(enc(LUI_T, rnd(), 5'd5, 5'd4, 5'd4, rnd()));
        push(enc(ARITH_IMM_T, XOR_FN3, 5'd6, 5'd2, 5'd4, rnd()));
        wait_idle();
        busy <= '0;
        end_test("conflicts", e);

        e = errors;  // back-pressure and flush
        held = alu_now();
        alu_ready <= 1'b0;
        push(enc(ARITH_T, OR_FN3, 5'd8, rnd(), rnd(), 7'b0));
        expect_stall(6);
        alu_ready <= 1'b1;
        flush <= 1'b1;
        expect_stall(6);
        check_alu(held, alu_now());
        flush <= 1'b0;
        wait_idle();
        for (int k = 0; k < 16; k++) begin
            if (k % 3 == 0) push(enc(BRANCH_T, rnd(), rnd(), rnd(), rnd(), rnd()));
            else push(enc(ARITH_IMM_T, rnd(), rnd(), rnd(), rnd(), 7'b0));
        end
        wait_idle();
        end_test("stall and stream", e);

        e = errors;  // load, store, system, muldiv
        for (int k = 0; k < 4; k++) begin
            if (k == 3) push(enc(ARITH_T, rnd(), rnd(), rnd(), rnd(), 7'b0000001));
            else push(enc((k == 0) ? 5'b00000 : (k == 1) ? 5'b01000 : 5'b11100,
                          rnd(), rnd(), rnd(), rnd(), rnd()));
            repeat (2) @(posedge clk);
            check_flag("illegal_instruction", 1'b1, illegal_instruction);
            expect_stall(6);
            buf_q.delete();
            repeat (2) @(posedge clk);
        end
        end_test("illegal", e);

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== decode_pkg.sv ====
// shared widths, opcode classes and alu codes for the decode/issue stage and its testbench
package decode_pkg;

    localparam int XLEN = 32;

    // ----------------------------------------
    // widths with a meaning
    // ----------------------------------------
    typedef logic [XLEN-1:0] xlen_t;   // data word or pc
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [2:0]      fn3_t;
    typedef logic [XLEN:0]   alu_operand_t; // msb is the signed-compare extension
    typedef logic [1:0]      alu_op_t;
    typedef logic [1:0]      alu_logic_op_t;

    // ----------------------------------------
    // trimmed opcodes from instr[6:2]
    // ----------------------------------------
    localparam logic [4:0] LUI_T       = 5'b01101;
    localparam logic [4:0] AUIPC_T     = 5'b00101;
    localparam logic [4:0] ARITH_T     = 5'b01100;
    localparam logic [4:0] ARITH_IMM_T = 5'b00100;
    localparam logic [4:0] BRANCH_T    = 5'b11000;
    localparam logic [4:0] JAL_T       = 5'b11011;
    localparam logic [4:0] JALR_T      = 5'b11001;

    // funct3 of the alu group
    localparam fn3_t ADD_SUB_FN3 = 3'b000;
    localparam fn3_t SLL_FN3     = 3'b001;
    localparam fn3_t SLT_FN3     = 3'b010;
    localparam fn3_t SLTU_FN3    = 3'b011;
    localparam fn3_t XOR_FN3     = 3'b100;
    localparam fn3_t SRA_FN3     = 3'b101; // srl shares it and bit 30 tells them apart
    localparam fn3_t OR_FN3      = 3'b110;
    localparam fn3_t AND_FN3     = 3'b111;

    // funct3 of the unsigned branch compares
    localparam fn3_t BLTU_FN3 = 3'b110;
    localparam fn3_t BGEU_FN3 = 3'b111;

    // alu result path
    localparam alu_op_t ALU_ADD_SUB = 2'd0;
    localparam alu_op_t ALU_SLT     = 2'd1;
    localparam alu_op_t ALU_SHIFT   = 2'd2;

    // logic function on the adder path
    localparam alu_logic_op_t ALU_LOGIC_ADD = 2'd0;
    localparam alu_logic_op_t ALU_LOGIC_XOR = 2'd1;
    localparam alu_logic_op_t ALU_LOGIC_OR  = 2'd2;
    localparam alu_logic_op_t ALU_LOGIC_AND = 2'd3;

endpackage

// ==== decoded_instr_if.sv ====
// decoded instruction fields, driven by the field decoder and read by issue and operand logic
`timescale 1ns/1ps

interface decoded_instr_if
    import decode_pkg::*;
();

    instr_t     instr;
    xlen_t      pc;
    fn3_t       fn3;
    logic [4:0] opcode_trim;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;

    logic uses_rs1;
    logic uses_rs2;
    logic uses_rd;   // low for x0 and for conditional branches

    logic is_alu;    // unit requests for legal encodings only
    logic is_branch;
    logic illegal;

    modport decoder (
        output instr, pc, fn3, opcode_trim, rs1_addr, rs2_addr, rd_addr,
        output uses_rs1, uses_rs2, uses_rd, is_alu, is_branch, illegal
    );

    modport consumer (
        input instr, pc, fn3, opcode_trim, rs1_addr, rs2_addr, rd_addr,
        input uses_rs1, uses_rs2, uses_rd, is_alu, is_branch, illegal
    );

endinterface

// ==== instr_field_decoder.sv ====
// combinational field slicing, unit classification and illegal flagging of the offered instruction
`timescale 1ns/1ps

module instr_field_decoder
    import decode_pkg::*;
(
    input logic              instr_valid,
    input instr_t            instr,
    input xlen_t             instr_pc,
    decoded_instr_if.decoder dec
);

    logic [4:0] opcode_trim;
    reg_addr_t  rd;
    logic       full_width;

    logic op_lui;
    logic op_auipc;
    logic op_arith;
    logic op_arith_imm;
    logic op_branch;
    logic op_jal;
    logic op_jalr;

    logic alu_req;
    logic branch_req;

    assign opcode_trim = instr[6:2];
    assign rd          = instr[11:7];
    assign full_width  = (instr[1:0] == 2'b11); // no compressed forms here

    // ----------------------------------------
    // raw fields
    // ----------------------------------------
    assign dec.instr       = instr;
    assign dec.pc          = instr_pc;
    assign dec.fn3         = instr[14:12];
    assign dec.opcode_trim = opcode_trim;
    assign dec.rs1_addr    = instr[19:15];
    assign dec.rs2_addr    = instr[24:20];
    assign dec.rd_addr     = rd;

    // ----------------------------------------
    // opcode classes
    // ----------------------------------------
    assign op_lui       = full_width && (opcode_trim == LUI_T);
    assign op_auipc     = full_width && (opcode_trim == AUIPC_T);
    assign op_arith     = full_width && (opcode_trim == ARITH_T);
    assign op_arith_imm = full_width && (opcode_trim == ARITH_IMM_T);
    assign op_branch    = full_width && (opcode_trim == BRANCH_T);
    assign op_jal       = full_width && (opcode_trim == JAL_T);
    assign op_jalr      = full_width && (opcode_trim == JALR_T);

    // bit 25 on OP selects mul/div, which this core lacks
    assign alu_req    = op_lui | op_auipc | op_arith_imm | (op_arith & ~instr[25]);
    assign branch_req = op_branch | op_jal | op_jalr;

    assign dec.is_alu    = alu_req;
    assign dec.is_branch = branch_req;

    // register usage
    assign dec.uses_rs1 = op_arith | op_arith_imm | op_branch | op_jalr;
    assign dec.uses_rs2 = op_arith | op_branch;
    assign dec.uses_rd  = (rd != '0) & (alu_req | op_jal | op_jalr);

    // anything neither unit takes
    assign dec.illegal = instr_valid & ~(alu_req | branch_req);

endmodule

// ==== issue_control.sv ====
// issue gating that combines valid, flush, source conflicts and unit readiness into issue and pop
`timescale 1ns/1ps

module issue_control
    import decode_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid,
    input  logic              flush,
    decoded_instr_if.consumer dec,
    input  logic              rs1_conflict,
    input  logic              rs2_conflict,
    input  logic              alu_ready,
    input  logic              branch_ready,
    output logic              alu_issue,
    output logic              branch_issue,
    output logic              pop,
    output logic              rd_issue,
    output reg_addr_t         rd_addr
);

    logic issue_en;        // set once reset has been released
    logic issue_valid;
    logic operands_ready;
    logic alu_unit_ok;
    logic branch_unit_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_en <= 1'b0;
        end else begin
            issue_en <= 1'b1;
        end
    end

    assign issue_valid = instr_valid & ~flush & issue_en;

    // unused sources never stall
    assign operands_ready = ~((dec.uses_rs1 & rs1_conflict) |
                              (dec.uses_rs2 & rs2_conflict));

    // ----------------------------------------
    // per unit readiness
    // ----------------------------------------
    assign alu_unit_ok = dec.is_alu & alu_ready;

    // branches without a writeback never wait on the branch unit
    assign branch_unit_ok = dec.is_branch & (branch_ready | ~dec.uses_rd);

    assign alu_issue    = issue_valid & operands_ready & alu_unit_ok;
    assign branch_issue = issue_valid & operands_ready & branch_unit_ok;

    assign pop = alu_issue | branch_issue; // exactly the issuing cycle

    // scoreboard notice for a new pending write
    assign rd_issue = pop & dec.uses_rd;
    assign rd_addr  = dec.rd_addr;

endmodule

// ==== operand_stage.sv ====
// forms the alu and branch operand bundles and registers them on issue with one cycle of latency
`timescale 1ns/1ps

module operand_stage
    import decode_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    decoded_instr_if.consumer dec,
    input  logic              alu_issue,
    input  logic              branch_issue,
    input  xlen_t             rs1_data,
    input  xlen_t             rs2_data,

    output logic              alu_valid,
    output alu_operand_t      alu_in1,
    output alu_operand_t      alu_in2,
    output xlen_t             alu_shifter_in,
    output logic              alu_subtract,
    output logic              alu_arith,
    output logic              alu_lshift,
    output alu_op_t           alu_op,
    output alu_logic_op_t     alu_logic_op,

    output logic              branch_valid,
    output xlen_t             branch_rs1,
    output xlen_t             branch_rs2,
    output xlen_t             branch_pc,
    output fn3_t              branch_fn3,
    output logic              branch_use_signed,
    output logic              branch_jal,
    output logic              branch_jalr,
    output logic              branch_rdx0
);

    logic          is_lui;
    logic          is_auipc;
    logic          is_upper;  // lui or auipc
    logic          is_arith;
    xlen_t         in1_data;
    xlen_t         in2_data;
    xlen_t         rs1_reversed;
    logic          sub_next;
    alu_op_t       op_next;
    alu_logic_op_t logic_op_next;

    assign is_lui   = (dec.opcode_trim == LUI_T);
    assign is_auipc = (dec.opcode_trim == AUIPC_T);
    assign is_upper = is_lui | is_auipc;
    assign is_arith = (dec.opcode_trim == ARITH_T);

    // ----------------------------------------
    // alu operands
    // ----------------------------------------
    always_comb begin
        if (is_lui) begin
            in1_data = '0;
        end else if (is_auipc) begin
            in1_data = dec.pc;
        end else begin
            in1_data = rs1_data;
        end

        if (is_upper) begin
            in2_data = {dec.instr[31:12], 12'b0};
        end else if (!is_arith) begin
            in2_data = xlen_t'(signed'(dec.instr[31:20])); // op-imm
        end else begin
            in2_data = rs2_data;
        end
    end

    // shifter only shifts right, so left shifts see rs1 reversed
    always_comb begin
        for (int i = 0; i < XLEN; i++) begin
            rs1_reversed[i] = rs1_data[XLEN-1-i];
        end
    end

    always_comb begin
        case (dec.fn3)
            SLT_FN3, SLTU_FN3: op_next = ALU_SLT;
            SLL_FN3, SRA_FN3:  op_next = ALU_SHIFT;
            default:           op_next = ALU_ADD_SUB;
        endcase

        case (dec.fn3)
            XOR_FN3: logic_op_next = ALU_LOGIC_XOR;
            OR_FN3:  logic_op_next = ALU_LOGIC_OR;
            AND_FN3: logic_op_next = ALU_LOGIC_AND;
            default: logic_op_next = ALU_LOGIC_ADD;
        endcase
    end

    // slt compares by subtracting and sub only exists on OP
    assign sub_next = ~is_upper & ((dec.fn3 inside {SLT_FN3, SLTU_FN3}) |
                                   ((dec.fn3 == ADD_SUB_FN3) & dec.instr[30] & is_arith));

    always_ff @(posedge clk) begin
        if (alu_issue) begin
            alu_in1        <= {in1_data[XLEN-1] & ~dec.fn3[0], in1_data};
            alu_in2        <= {in2_data[XLEN-1] & ~dec.fn3[0], in2_data};
            alu_shifter_in <= dec.fn3[2] ? rs1_data : rs1_reversed;
            alu_subtract   <= sub_next;
            alu_arith      <= rs1_data[XLEN-1] & dec.instr[30]; // sra fill bit
            alu_lshift     <= ~dec.fn3[2];
            alu_op         <= is_upper ? ALU_ADD_SUB : op_next;
            alu_logic_op   <= is_upper ? ALU_LOGIC_ADD : logic_op_next;
        end
    end

    // ----------------------------------------
    // branch operands
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (branch_issue) begin
            branch_rs1        <= rs1_data;
            branch_rs2        <= rs2_data;
            branch_pc         <= dec.pc;
            branch_fn3        <= dec.fn3;
            branch_use_signed <= !(dec.fn3 inside {BLTU_FN3, BGEU_FN3});
            branch_jal        <= (dec.opcode_trim == JAL_T);
            branch_jalr       <= (dec.opcode_trim == JALR_T);
            branch_rdx0       <= ~dec.uses_rd;
        end
    end

    // strobes trail the issue pulse by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid    <= 1'b0;
            branch_valid <= 1'b0;
        end else begin
            alu_valid    <= alu_issue;
            branch_valid <= branch_issue;
        end
    end

endmodule
